// ==== include/z80_config.svh ====
`ifndef Z80_CONFIG_SVH
`define Z80_CONFIG_SVH

// T-states per machine cycle, the io count includes the automatic wait
`define Z80_M1_TSTATES  4
`define Z80_MEM_TSTATES 3
`define Z80_IO_TSTATES  4

// program counter value after reset
`define Z80_RESET_PC 16'h0000

// opcodes of the supported instruction subset
`define OP_NOP     8'h00
`define OP_LD_A_N  8'h3E
`define OP_LD_NN_A 8'h32
`define OP_LD_A_NN 8'h3A
`define OP_OUT_N_A 8'hD3
`define OP_IN_A_N  8'hDB
`define OP_JP_NN   8'hC3
`define OP_HALT    8'h76

`endif

// ==== sources.f ====
+incdir+include
verilog/z80_pkg.sv
verilog/z80_bus_if.sv
verilog/sequencer.sv
verilog/mcycle.sv
verilog/z80.sv
testbench/tb_z80.sv

// ==== testbench/tb_z80.sv ====
`timescale 1ns/1ps

`include "z80_config.svh"

module tb_z80;
    import z80_pkg::*;

    localparam integer N_INSTR        = 200;
    localparam integer HALT_REPEATS   = 20;
    localparam integer MAX_EXP        = 1024;
    localparam integer TIMEOUT_CYCLES = N_INSTR * 3 * (`Z80_M1_TSTATES + 3) * 2;

    // transaction kinds seen on the bus
    localparam integer K_M1   = 0;
    localparam integer K_MRD  = 1;
    localparam integer K_MWR  = 2;
    localparam integer K_IORD = 3;
    localparam integer K_IOWR = 4;
    // strobes that fit no cycle kind
    localparam integer K_NONE = 5;

    logic  clk = 1'b0;
    logic  rst;
    logic  wait_n;
    data_t read_d;
    addr_t addr;
    data_t write_d;
    logic  mreq_n;
    logic  iorq_n;
    logic  rd_n;
    logic  wr_n;
    logic  m1_n;
    logic  rfsh_n;
    logic [29:0] pin_vec;

    data_t    mem [0:65535];
    data_t    model_mem [0:65535];
    data_t    prog_op [0:N_INSTR-1];
    addr_t    prog_at [0:N_INSTR-1];
    integer   exp_kind [0:MAX_EXP-1];
    addr_t    exp_addr [0:MAX_EXP-1];
    data_t    exp_data [0:MAX_EXP-1];
    refresh_t exp_r [0:MAX_EXP-1];
    integer   n_exp = 0;

    integer seed          = 32'h39f1;
    integer wait_left     = 0;
    integer idx           = 0;
    integer errors        = 0;
    integer cycles        = 0;
    integer since_rst     = 0;
    integer since_capture = 0;
    integer obs_kind      = 0;
    integer last_kind     = 0;
    addr_t  obs_addr;
    data_t  obs_data;
    logic   prev_rd   = 1'b1;
    logic   prev_wr   = 1'b1;
    logic   prev_m1   = 1'b1;
    logic   prev_wait = 1'b1;
    logic [29:0] prev_vec;

    z80 z80_i (
        .clk     (clk),
        .rst     (rst),
        .wait_n  (wait_n),
        .read_d  (read_d),
        .addr    (addr),
        .write_d (write_d),
        .mreq_n  (mreq_n),
        .iorq_n  (iorq_n),
        .rd_n    (rd_n),
        .wr_n    (wr_n),
        .m1_n    (m1_n),
        .rfsh_n  (rfsh_n)
    );

    assign pin_vec = {addr, write_d, mreq_n, iorq_n, rd_n, wr_n, m1_n, rfsh_n};

    always #4 clk = ~clk;

    // i/o devices answer with a byte made from the port address
    function automatic data_t io_byte(input addr_t port);
        return port[15:8] ^ {port[6:0], port[7]} ^ 8'ha5;
    endfunction

    function automatic integer instr_len(input data_t op);
        case (op)
            `OP_LD_A_N, `OP_OUT_N_A, `OP_IN_A_N: return 2;
            `OP_LD_NN_A, `OP_LD_A_NN, `OP_JP_NN: return 3;
            default: return 1;
        endcase
    endfunction

    function automatic logic known_opcode(input data_t op);
        case (op)
            `OP_NOP, `OP_LD_A_N, `OP_LD_NN_A, `OP_LD_A_NN,
            `OP_OUT_N_A, `OP_IN_A_N, `OP_JP_NN, `OP_HALT: return 1'b1;
            default: return 1'b0;
        endcase
    endfunction

    function automatic integer cycle_len(input integer kind);
        if (kind == K_M1) begin
            return `Z80_M1_TSTATES;
        end else if (kind == K_MRD || kind == K_MWR) begin
            return `Z80_MEM_TSTATES;
        end
        return `Z80_IO_TSTATES;
    endfunction

    // clocks from T1 to the first sample with rd_n or wr_n back high
    function automatic integer rise_offset(input integer kind);
        return (kind == K_IORD || kind == K_IOWR) ? 3 : 2;
    endfunction

    task automatic report_mismatch(input string name, input logic [31:0] expected,
                                   input logic [31:0] actual);
        errors = errors + 1;
        $display("Fail %s: expected %0h, actual %0h", name, expected, actual);
    endtask

    task automatic push_expect(input integer kind, input addr_t a, input data_t d,
                               input refresh_t r);
        exp_kind[n_exp] = kind;
        exp_addr[n_exp] = a;
        exp_data[n_exp] = d;
        exp_r[n_exp]    = r;
        n_exp = n_exp + 1;
    endtask

    task automatic build_program;
        integer f;
        integer i;
        integer t;
        integer pick;
        addr_t  pc_acc;
        addr_t  a;
        data_t  op;
        for (f = 0; f < 65536; f = f + 1) begin
            mem[f] = f[15:8] ^ f[7:0] ^ 8'h5c;
        end
        // layout first, so jump targets are known
        pc_acc = `Z80_RESET_PC;
        for (i = 0; i < N_INSTR; i = i + 1) begin
            op = `OP_HALT;
            if (i < N_INSTR - 1) begin
                pick = $unsigned($random(seed)) % 9;
                case (pick)
                    0: op = `OP_NOP;
                    1, 8: op = `OP_LD_A_N;
                    2: op = `OP_LD_NN_A;
                    3: op = `OP_LD_A_NN;
                    4: op = `OP_OUT_N_A;
                    5: op = `OP_IN_A_N;
                    6: op = `OP_JP_NN;
                    default: begin
                        op = data_t'($random(seed));
                        while (known_opcode(op)) begin
                            op = data_t'($random(seed));
                        end
                    end
                endcase
            end
            prog_op[i] = op;
            prog_at[i] = pc_acc;
            pc_acc = pc_acc + addr_t'(instr_len(op));
        end
        for (i = 0; i < N_INSTR; i = i + 1) begin
            a = prog_at[i];
            mem[a] = prog_op[i];
            case (prog_op[i])
                `OP_LD_A_N, `OP_OUT_N_A, `OP_IN_A_N: begin
                    mem[a + 16'd1] = data_t'($random(seed));
                end
                `OP_LD_NN_A, `OP_LD_A_NN: begin
                    // data region at 8000h stays clear of the program
                    mem[a + 16'd1] = data_t'($random(seed));
                    mem[a + 16'd2] = 8'h80;
                end
                `OP_JP_NN: begin
                    // forward jumps only, so HALT is always reached
                    t = i + 1 + $unsigned($random(seed)) % 8;
                    if (t > N_INSTR - 1) begin
                        t = N_INSTR - 1;
                    end
                    mem[a + 16'd1] = prog_at[t][7:0];
                    mem[a + 16'd2] = prog_at[t][15:8];
                end
                default: begin
                end
            endcase
        end
    endtask

    // instruction-level model that lists every expected bus transaction
    task automatic run_model;
        integer   k;
        addr_t    pc;
        addr_t    nn;
        data_t    a;
        data_t    op;
        data_t    lo;
        data_t    hi;
        refresh_t r;
        logic     halted;
        for (k = 0; k < 65536; k = k + 1) begin
            model_mem[k] = mem[k];
        end
        pc = `Z80_RESET_PC;
        a = 8'h00;
        r = '0;
        halted = 1'b0;
        while (!halted) begin
            op = model_mem[pc];
            push_expect(K_M1, pc, op, r);
            r = r + 7'd1;
            lo = model_mem[pc + 16'd1];
            hi = model_mem[pc + 16'd2];
            case (op)
                `OP_HALT: begin
                    halted = 1'b1;
                end
                `OP_LD_A_N: begin
                    push_expect(K_MRD, pc + 16'd1, lo, '0);
                    a = lo;
                    pc = pc + 16'd2;
                end
                `OP_OUT_N_A, `OP_IN_A_N: begin
                    push_expect(K_MRD, pc + 16'd1, lo, '0);
                    nn = {a, lo};
                    if (op == `OP_OUT_N_A) begin
                        push_expect(K_IOWR, nn, a, '0);
                    end else begin
                        a = io_byte(nn);
                        push_expect(K_IORD, nn, a, '0);
                    end
                    pc = pc + 16'd2;
                end
                `OP_LD_NN_A, `OP_LD_A_NN, `OP_JP_NN: begin
                    push_expect(K_MRD, pc + 16'd1, lo, '0);
                    push_expect(K_MRD, pc + 16'd2, hi, '0);
                    nn = {hi, lo};
                    pc = pc + 16'd3;
                    if (op == `OP_JP_NN) begin
                        pc = nn;
                    end else if (op == `OP_LD_NN_A) begin
                        model_mem[nn] = a;
                        push_expect(K_MWR, nn, a, '0);
                    end else begin
                        a = model_mem[nn];
                        push_expect(K_MRD, nn, a, '0);
                    end
                end
                default: begin
                    pc = pc + 16'd1;
                end
            endcase
        end
        // halted part keeps fetching at the halt address
        for (k = 0; k < HALT_REPEATS; k = k + 1) begin
            push_expect(K_M1, pc, `OP_HALT, r);
            r = r + 7'd1;
        end
    endtask

    initial begin
        rst = 1'b1;
        wait_n = 1'b1;
        read_d = 8'h00;
        build_program();
        run_model();
        repeat (4) @(posedge clk);
        #1;
        rst = 1'b0;
    end

    // memory and i/o answers with random wait stretches
    always @(posedge clk) begin
        #1;
        if (!iorq_n) begin
            read_d = io_byte(addr);
        end else begin
            read_d = mem[addr];
        end
        if (rst) begin
            wait_n = 1'b1;
        end else if (wait_left > 0) begin
            wait_n = 1'b0;
            wait_left = wait_left - 1;
        end else begin
            wait_n = 1'b1;
            if (($random(seed) & 3) == 0) begin
                wait_left = $unsigned($random(seed)) % 4;
            end
        end
    end

    always @(negedge wr_n) begin
        #1;
        if (!mreq_n) begin
            mem[addr] = write_d;
        end
    end

    // bus monitor samples the pins half a clock after they change
    always @(negedge clk) begin
        cycles = cycles + 1;
        since_capture = since_capture + 1;
        if (rst || since_rst < 2) begin
            if (pin_vec !== {16'h0000, 8'h00, 6'h3f}) begin
                report_mismatch("reset pins", {16'h0000, 8'h00, 6'h3f}, pin_vec);
            end
        end
        if (rst) begin
            since_rst = 0;
        end else begin
            since_rst = since_rst + 1;
        end
        // a low wait_n while rd_n or wr_n is low never moves any pin
        if (!prev_wait && (!prev_rd || !prev_wr) && pin_vec !== prev_vec) begin
            errors = errors + 1;
            $display("pins changed while wait_n was low, clock %0d", cycles);
        end
        if (!rd_n || !wr_n) begin
            obs_addr = addr;
            obs_data = !wr_n ? write_d : read_d;
            if (!m1_n && !mreq_n) begin
                obs_kind = K_M1;
            end else if (!iorq_n) begin
                obs_kind = !wr_n ? K_IOWR : K_IORD;
            end else if (!mreq_n) begin
                obs_kind = !wr_n ? K_MWR : K_MRD;
            end else begin
                obs_kind = K_NONE;
            end
        end
        if ((rd_n && !prev_rd) || (wr_n && !prev_wr) || (m1_n && !prev_m1)) begin
            if (idx == 0 && obs_addr !== `Z80_RESET_PC) begin
                report_mismatch("first fetch address", `Z80_RESET_PC, obs_addr);
            end
            if (obs_kind != exp_kind[idx]) begin
                report_mismatch($sformatf("kind of transaction %0d", idx),
                                exp_kind[idx], obs_kind);
            end
            if (obs_addr !== exp_addr[idx]) begin
                report_mismatch($sformatf("address of transaction %0d", idx),
                                exp_addr[idx], obs_addr);
            end
            if (obs_data !== exp_data[idx]) begin
                report_mismatch($sformatf("data of transaction %0d", idx),
                                exp_data[idx], obs_data);
            end
            if (obs_kind == K_M1 && (rfsh_n !== 1'b0 || addr !== {9'd0, exp_r[idx]})) begin
                report_mismatch($sformatf("refresh address of transaction %0d", idx),
                                {9'd0, exp_r[idx]}, addr);
            end
            // the request clock sits between the last T-state and the next T1
            if (idx > 0 && since_capture < cycle_len(last_kind) - rise_offset(last_kind)
                    + 1 + rise_offset(obs_kind)) begin
                errors = errors + 1;
                $display("transaction %0d came only %0d clocks after the previous one",
                         idx, since_capture);
            end
            last_kind = obs_kind;
            since_capture = 0;
            idx = idx + 1;
        end
        prev_rd   = rd_n;
        prev_wr   = wr_n;
        prev_m1   = m1_n;
        prev_wait = wait_n;
        prev_vec  = pin_vec;
        if (idx == n_exp) begin
            $display("checked %0d of %0d transactions, %0d errors", idx, n_exp, errors);
            if (errors == 0) begin
                $display("Test passed");
            end else begin
                $display("Test failed");
            end
            $finish;
        end else if (cycles >= TIMEOUT_CYCLES) begin
            $display("timeout: program did not reach HALT");
            $display("checked %0d of %0d transactions, %0d errors", idx, n_exp, errors);
            $display("Test failed");
            $finish;
        end
    end

endmodule

// ==== verilog/mcycle.sv ====
`timescale 1ns/1ps

`include "z80_config.svh"

module mcycle (
    input  logic             clk,
    input  logic             rst,
    input  logic             wait_n,
    input  z80_pkg::data_t   read_d,
    z80_bus_if.cyc           bus,
    output z80_pkg::addr_t   addr,
    output z80_pkg::data_t   write_d,
    output logic             mreq_n,
    output logic             iorq_n,
    output logic             rd_n,
    output logic             wr_n,
    output logic             m1_n,
    output logic             rfsh_n
);
    import z80_pkg::*;

    localparam tstate_t M1_LAST   = tstate_t'(`Z80_M1_TSTATES);
    localparam tstate_t MEM_LAST  = tstate_t'(`Z80_MEM_TSTATES);
    localparam tstate_t IO_LAST   = tstate_t'(`Z80_IO_TSTATES);
    // wait_n is looked at in T2, or in TW for io
    localparam tstate_t WAIT_T    = 3'd2;
    localparam tstate_t IO_WAIT_T = 3'd3;

    logic     busy;
    tstate_t  tstate;
    cycle_t   cur_cycle;
    logic     cur_wr;
    refresh_t refresh;
    data_t    rdata_q;
    logic     done_q;

    logic     start;
    tstate_t  wait_t;
    logic     at_wait;
    logic     stall;
    logic     last_t;
    logic     is_read;

    logic     nxt_busy;
    tstate_t  nxt_tstate;
    cycle_t   nxt_cycle;
    logic     nxt_wr;

    // active-high strobes for the coming T-state
    logic     s_mreq;
    logic     s_iorq;
    logic     s_rd;
    logic     s_wr;
    logic     s_m1;
    logic     s_rfsh;

    function automatic tstate_t last_tstate(input cycle_t c);
        case (c)
            CYCLE_M1:  return M1_LAST;
            CYCLE_MEM: return MEM_LAST;
            CYCLE_IO:  return IO_LAST;
            default:   return 3'd1;
        endcase
    endfunction

    assign start   = !busy && (bus.cycle != CYCLE_NONE);
    assign wait_t  = (cur_cycle == CYCLE_IO) ? IO_WAIT_T : WAIT_T;
    assign at_wait = busy && (tstate == wait_t);
    assign stall   = at_wait && !wait_n;
    assign last_t  = (tstate == last_tstate(cur_cycle));
    assign is_read = (cur_cycle == CYCLE_M1) || !cur_wr;

    always_comb begin
        nxt_busy   = busy;
        nxt_tstate = tstate;
        nxt_cycle  = cur_cycle;
        nxt_wr     = cur_wr;
        if (!busy) begin
            if (start) begin
                nxt_busy   = 1'b1;
                nxt_tstate = 3'd1;
                nxt_cycle  = bus.cycle;
                nxt_wr     = bus.wr;
            end
        end else if (!stall) begin
            if (last_t) begin
                nxt_busy  = 1'b0;
                nxt_cycle = CYCLE_NONE;
            end else begin
                nxt_tstate = tstate + 3'd1;
            end
        end
    end

    // a stalled state maps to the same strobes, so outputs hold during waits
    always_comb begin
        s_mreq = 1'b0;
        s_iorq = 1'b0;
        s_rd   = 1'b0;
        s_wr   = 1'b0;
        s_m1   = 1'b0;
        s_rfsh = 1'b0;
        if (nxt_busy) begin
            case (nxt_cycle)
                CYCLE_M1: begin
                    s_m1   = (nxt_tstate <= 3'd2);
                    s_rd   = (nxt_tstate <= 3'd2);
                    s_mreq = (nxt_tstate <= 3'd3);
                    s_rfsh = (nxt_tstate >= 3'd3);
                end
                CYCLE_MEM: begin
                    s_mreq = nxt_wr || (nxt_tstate <= 3'd2);
                    s_rd   = !nxt_wr && (nxt_tstate <= 3'd2);
                    s_wr   = nxt_wr && (nxt_tstate == 3'd2);
                end
                CYCLE_IO: begin
                    s_iorq = (nxt_tstate == 3'd2) || (nxt_tstate == IO_WAIT_T);
                    s_rd   = !nxt_wr && s_iorq;
                    s_wr   = nxt_wr && s_iorq;
                end
                default: begin
                    s_mreq = 1'b0;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            busy      <= 1'b0;
            tstate    <= 3'd1;
            cur_cycle <= CYCLE_NONE;
            cur_wr    <= 1'b0;
            refresh   <= '0;
            done_q    <= 1'b0;
            addr      <= '0;
            write_d   <= '0;
            mreq_n    <= 1'b1;
            iorq_n    <= 1'b1;
            rd_n      <= 1'b1;
            wr_n      <= 1'b1;
            m1_n      <= 1'b1;
            rfsh_n    <= 1'b1;
        end else begin
            busy      <= nxt_busy;
            tstate    <= nxt_tstate;
            cur_cycle <= nxt_cycle;
            cur_wr    <= nxt_wr;
            done_q    <= nxt_busy && (nxt_tstate == last_tstate(nxt_cycle));
            mreq_n    <= !s_mreq;
            iorq_n    <= !s_iorq;
            rd_n      <= !s_rd;
            wr_n      <= !s_wr;
            m1_n      <= !s_m1;
            rfsh_n    <= !s_rfsh;
            if (start) begin
                addr <= bus.addr;
                if (bus.wr && bus.cycle != CYCLE_M1) begin
                    write_d <= bus.wdata;
                end
            end else if (nxt_cycle == CYCLE_M1 && nxt_tstate >= 3'd3) begin
                // refresh address, I is always zero here
                addr <= {8'h00, 1'b0, refresh};
            end
            // R steps once per opcode fetch, after T4
            if (busy && cur_cycle == CYCLE_M1 && last_t) begin
                refresh <= refresh + 7'd1;
            end
        end
    end

    // read data is taken at the end of T2, or TW for io
    always_ff @(posedge clk) begin
        if (at_wait && wait_n && is_read) begin
            rdata_q <= read_d;
        end
    end

    assign bus.busy  = busy;
    assign bus.done  = done_q;
    assign bus.rdata = rdata_q;

    no_rd_wr_overlap: assert property (
        @(posedge clk) disable iff (rst)
        !(!rd_n && !wr_n)
    );

    no_mreq_iorq_overlap: assert property (
        @(posedge clk) disable iff (rst)
        !(!mreq_n && !iorq_n)
    );

    strobes_idle_when_free: assert property (
        @(posedge clk) disable iff (rst)
        !busy |-> (mreq_n && iorq_n && rd_n && wr_n && m1_n && rfsh_n)
    );

endmodule

// ==== verilog/sequencer.sv ====
`timescale 1ns/1ps

`include "z80_config.svh"

module sequencer (
    input  logic      clk,
    input  logic      rst,
    z80_bus_if.seq    bus
);
    import z80_pkg::*;

    seq_state_t state;
    seq_state_t nxt_state;
    addr_t      pc;
    addr_t      nxt_pc;
    addr_t      pc_inc;
    data_t      a_reg;
    data_t      nxt_a;
    data_t      opcode;
    data_t      operand_lo;

    // first fetch is issued in the clock after reset
    logic       kick;

    logic       req_valid;
    cycle_t     req_cycle;
    logic       req_wr;
    addr_t      req_addr;
    data_t      req_wdata;

    assign pc_inc = pc + 16'd1;

    // decode happens in the clock where done is high, so the next request
    // is ready right after the current cycle
    always_comb begin
        nxt_state = state;
        nxt_pc    = pc;
        nxt_a     = a_reg;
        req_valid = 1'b0;
        req_cycle = CYCLE_M1;
        req_wr    = 1'b0;
        req_addr  = pc;
        req_wdata = a_reg;

        if (kick) begin
            req_valid = 1'b1;
        end else if (bus.done) begin
            req_valid = 1'b1;
            case (state)
                FETCH: begin
                    // halt keeps pc on the halt opcode
                    if (bus.rdata != `OP_HALT) begin
                        nxt_pc   = pc_inc;
                        req_addr = pc_inc;
                    end
                    case (bus.rdata)
                        `OP_HALT: begin
                            nxt_state = HALTED;
                        end
                        `OP_LD_A_N, `OP_OUT_N_A, `OP_IN_A_N,
                        `OP_LD_NN_A, `OP_LD_A_NN, `OP_JP_NN: begin
                            nxt_state = OPERAND_LO;
                            req_cycle = CYCLE_MEM;
                        end
                        // NOP and every unknown opcode
                        default: begin
                            nxt_state = FETCH;
                        end
                    endcase
                end
                OPERAND_LO: begin
                    nxt_pc   = pc_inc;
                    req_addr = pc_inc;
                    case (opcode)
                        `OP_LD_A_N: begin
                            nxt_a     = bus.rdata;
                            nxt_state = FETCH;
                        end
                        `OP_OUT_N_A, `OP_IN_A_N: begin
                            // port address carries A on the high byte
                            nxt_state = EXECUTE;
                            req_cycle = CYCLE_IO;
                            req_wr    = (opcode == `OP_OUT_N_A);
                            req_addr  = {a_reg, bus.rdata};
                        end
                        default: begin
                            nxt_state = OPERAND_HI;
                            req_cycle = CYCLE_MEM;
                        end
                    endcase
                end
                OPERAND_HI: begin
                    nxt_pc   = pc_inc;
                    req_addr = {bus.rdata, operand_lo};
                    if (opcode == `OP_JP_NN) begin
                        nxt_pc    = {bus.rdata, operand_lo};
                        nxt_state = FETCH;
                    end else begin
                        nxt_state = EXECUTE;
                        req_cycle = CYCLE_MEM;
                        req_wr    = (opcode == `OP_LD_NN_A);
                    end
                end
                EXECUTE: begin
                    if (opcode == `OP_LD_A_NN || opcode == `OP_IN_A_N) begin
                        nxt_a = bus.rdata;
                    end
                    nxt_state = FETCH;
                end
                HALTED: begin
                    // fetched byte is thrown away
                    nxt_state = HALTED;
                end
                default: begin
                    nxt_state = FETCH;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state     <= FETCH;
            pc        <= `Z80_RESET_PC;
            a_reg     <= '0;
            kick      <= 1'b1;
            bus.cycle <= CYCLE_NONE;
        end else begin
            state     <= nxt_state;
            pc        <= nxt_pc;
            a_reg     <= nxt_a;
            kick      <= 1'b0;
            // request is a single-clock strobe
            bus.cycle <= req_valid ? req_cycle : CYCLE_NONE;
        end
    end

    always_ff @(posedge clk) begin
        if (bus.done && state == FETCH) begin
            opcode <= bus.rdata;
        end
        if (bus.done && state == OPERAND_LO) begin
            operand_lo <= bus.rdata;
        end
        if (req_valid) begin
            bus.wr    <= req_wr;
            bus.addr  <= req_addr;
            bus.wdata <= req_wdata;
        end
    end

    // mcycle must be idle when a request shows up, or it would be dropped
    req_only_when_idle: assert property (
        @(posedge clk) disable iff (rst)
        bus.cycle != CYCLE_NONE |-> !bus.busy
    );

endmodule

// ==== verilog/z80.sv ====
`timescale 1ns/1ps

module z80 (
    input  logic           clk,
    input  logic           rst,
    input  logic           wait_n,
    input  z80_pkg::data_t read_d,
    output z80_pkg::addr_t addr,
    output z80_pkg::data_t write_d,
    output logic           mreq_n,
    output logic           iorq_n,
    output logic           rd_n,
    output logic           wr_n,
    output logic           m1_n,
    output logic           rfsh_n
);

    // one machine-cycle request at a time between the two blocks
    z80_bus_if bus ();

    // instruction fetch, decode and execute
    sequencer sequencer_i (
        .clk (clk),
        .rst (rst),
        .bus (bus.seq)
    );

    // turns each request into T-states on the pins
    mcycle mcycle_i (
        .clk     (clk),
        .rst     (rst),
        .wait_n  (wait_n),
        .read_d  (read_d),
        .bus     (bus.cyc),
        .addr    (addr),
        .write_d (write_d),
        .mreq_n  (mreq_n),
        .iorq_n  (iorq_n),
        .rd_n    (rd_n),
        .wr_n    (wr_n),
        .m1_n    (m1_n),
        .rfsh_n  (rfsh_n)
    );

endmodule

// ==== verilog/z80_bus_if.sv ====
`timescale 1ns/1ps

interface z80_bus_if;
    import z80_pkg::*;

    // request side, cycle is non-NONE for a single clock
    cycle_t cycle;
    logic   wr;
    addr_t  addr;
    data_t  wdata;

    // result side
    data_t  rdata;
    logic   done;
    logic   busy;

    modport seq (
        output cycle, wr, addr, wdata,
        input  rdata, done, busy
    );

    modport cyc (
        input  cycle, wr, addr, wdata,
        output rdata, done, busy
    );

endinterface

// ==== verilog/z80_pkg.sv ====
package z80_pkg;

    // 16-bit address bus
    typedef logic [15:0] addr_t;

    // 8-bit data bus
    typedef logic [7:0] data_t;

    // refresh counter R, only the low 7 bits count
    typedef logic [6:0] refresh_t;

    // T-state number inside a machine cycle, T1 is 1
    typedef logic [2:0] tstate_t;

    // machine cycle kinds requested by the sequencer
    typedef enum logic [1:0] {
        CYCLE_NONE = 2'd0,
        CYCLE_M1   = 2'd1,
        CYCLE_MEM  = 2'd2,
        CYCLE_IO   = 2'd3
    } cycle_t;

    // sequencer FSM
    //   FETCH       waiting for the opcode fetch
    //   OPERAND_LO  waiting for the first operand byte
    //   OPERAND_HI  waiting for the second operand byte
    //   EXECUTE     waiting for the data cycle
    //   HALTED      repeating opcode fetches at the halt address
    typedef enum logic [2:0] {
        FETCH      = 3'd0,
        OPERAND_LO = 3'd1,
        OPERAND_HI = 3'd2,
        EXECUTE    = 3'd3,
        HALTED     = 3'd4
    } seq_state_t;

endpackage
